// ==== Makefile ====
OBJ_DIR = obj_dir

all: run

build:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_multi_timer -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/Vtb_multi_timer

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_multi_timer

clean:
	rm -rf $(OBJ_DIR)

.PHONY: all build run lint clean

// ==== rtl/clock_watch.sv ====
`timescale 1ns/100ps

module clock_watch #(
    parameter int SEC_DIV = 100_000_000
) (
    input  logic             clk,
    input  logic             reset_p,
    input  logic             enable,
    input  timer_pkg::btn_t  btn,
    output timer_pkg::disp_t disp
);
    // 1 while setting, 0 while running
    logic set_mode;
    logic sec_tick;
    // hi = minutes, lo = seconds
    timer_pkg::disp_t cur;

    // divider frozen when inactive or being set
    tick_gen #(
        .DIV(SEC_DIV)
    ) u_tick_gen (
        .clk(clk),
        .reset_p(reset_p),
        .run(enable && !set_mode),
        .clear(1'b0),
        .tick(sec_tick)
    );

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            set_mode <= 1'b0;
            cur <= '0;
        end else if (enable) begin
            if (btn.b0) begin
                set_mode <= ~set_mode;
            end
            if (set_mode) begin
                // manual adjust, no carry between fields
                if (btn.b1) begin
                    cur.lo <= timer_pkg::wrap_inc(cur.lo, timer_pkg::sec_max);
                end
                if (btn.b2) begin
                    cur.hi <= timer_pkg::wrap_inc(cur.hi, timer_pkg::sec_max);
                end
            end else if (sec_tick) begin
                cur.lo <= timer_pkg::wrap_inc(cur.lo, timer_pkg::sec_max);
                // seconds roll over into minutes
                if (cur.lo == timer_pkg::sec_max) begin
                    cur.hi <= timer_pkg::wrap_inc(cur.hi, timer_pkg::sec_max);
                end
            end
        end
    end

    assign disp = cur;

endmodule

// ==== rtl/cook_timer.sv ====
`timescale 1ns/100ps

module cook_timer #(
    parameter int SEC_DIV = 100_000_000
) (
    input  logic             clk,
    input  logic             reset_p,
    input  logic             enable,
    input  timer_pkg::btn_t  btn,
    output timer_pkg::disp_t disp,
    output logic             alarm
);
    // b0 start, b1 +sec, b2 +min, b3 alarm off
    logic counting;
    logic sec_tick;
    logic is_zero;
    // hi = minutes, lo = seconds
    timer_pkg::disp_t cur;
    // last stored setting, recalled at 00:00
    timer_pkg::disp_t preset;

    assign is_zero = (cur == '0);

    tick_gen #(
        .DIV(SEC_DIV)
    ) u_tick_gen (
        .clk(clk),
        .reset_p(reset_p),
        .run(enable && counting),
        .clear(1'b0),
        .tick(sec_tick)
    );

    ////////////////////////////////////////////////////////////////////////////
    // run flag, alarm and preset
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            counting <= 1'b0;
            alarm <= 1'b0;
            preset <= '0;
        end else if (enable) begin
            // nothing to count from 00:00
            if (btn.b0 && !is_zero) begin
                counting <= ~counting;
            end
            // reached zero, stop and ring
            if (is_zero && counting) begin
                counting <= 1'b0;
                alarm <= 1'b1;
            end
            // any setting button silences the alarm
            if (btn.b3 || btn.b1 || btn.b2) begin
                alarm <= 1'b0;
            end
            if (btn.b3 && !counting && !is_zero) begin
                preset <= cur;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // time value
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cur <= '0;
        end else if (enable) begin
            if (counting) begin
                // hold at 00:00 until the run flag drops
                if (sec_tick && !is_zero) begin
                    if (cur.lo == '0) begin
                        // borrow a minute
                        cur.lo <= timer_pkg::sec_max;
                        cur.hi <= cur.hi - timer_pkg::time_w'(1);
                    end else begin
                        cur.lo <= cur.lo - timer_pkg::time_w'(1);
                    end
                end
            end else begin
                if (btn.b1) begin
                    cur.lo <= timer_pkg::wrap_inc(cur.lo, timer_pkg::sec_max);
                end
                if (btn.b2) begin
                    cur.hi <= timer_pkg::wrap_inc(cur.hi, timer_pkg::sec_max);
                end
                // alarm off at 00:00 recalls the stored setting
                if (btn.b3 && is_zero) begin
                    cur <= preset;
                end
            end
        end
    end

    assign disp = cur;

endmodule

// ==== rtl/mode_ctrl.sv ====
`timescale 1ns/100ps

module mode_ctrl (
    input  logic             clk,
    input  logic             reset_p,
    input  logic             mode_btn,
    input  timer_pkg::btn_t  btn,
    input  timer_pkg::disp_t watch_disp,
    input  timer_pkg::disp_t timer_disp,
    input  timer_pkg::disp_t stop_disp,
    output timer_pkg::mode_t mode,
    output logic             watch_en,
    output logic             timer_en,
    output logic             stop_en,
    output timer_pkg::btn_t  watch_btn,
    output timer_pkg::btn_t  timer_btn,
    output timer_pkg::btn_t  stop_btn,
    output timer_pkg::disp_t disp
);
    // watch -> timer -> stopwatch -> watch
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            mode <= timer_pkg::mode_watch;
        end else if (mode_btn) begin
            case (mode)
                timer_pkg::mode_watch: mode <= timer_pkg::mode_timer;
                timer_pkg::mode_timer: mode <= timer_pkg::mode_stop;
                default:               mode <= timer_pkg::mode_watch;
            endcase
        end
    end

    // one-hot enables from the mode register
    assign watch_en = (mode == timer_pkg::mode_watch);
    assign timer_en = (mode == timer_pkg::mode_timer);
    assign stop_en = (mode == timer_pkg::mode_stop);

    // idle functions see no presses
    assign watch_btn = watch_en ? btn : '0;
    assign timer_btn = timer_en ? btn : '0;
    assign stop_btn = stop_en ? btn : '0;

    always_comb begin
        case (mode)
            timer_pkg::mode_timer: disp = timer_disp;
            timer_pkg::mode_stop:  disp = stop_disp;
            default:               disp = watch_disp;
        endcase
    end

endmodule

// ==== rtl/multi_timer_top.sv ====
`timescale 1ns/100ps

module multi_timer_top #(
    parameter int SEC_DIV = 100_000_000,
    parameter int CSEC_DIV = 1_000_000
) (
    input  logic             clk,
    input  logic             reset_p,
    input  logic             mode_btn,
    input  timer_pkg::btn_t  btn,
    output timer_pkg::disp_t disp,
    output timer_pkg::mode_t mode,
    output logic             alarm
);
    logic watch_en;
    logic timer_en;
    logic stop_en;
    timer_pkg::btn_t watch_btn;
    timer_pkg::btn_t timer_btn;
    timer_pkg::btn_t stop_btn;
    timer_pkg::disp_t watch_disp;
    timer_pkg::disp_t timer_disp;
    timer_pkg::disp_t stop_disp;

    // mode owns buttons and display
    mode_ctrl u_mode_ctrl (
        .clk(clk),
        .reset_p(reset_p),
        .mode_btn(mode_btn),
        .btn(btn),
        .watch_disp(watch_disp),
        .timer_disp(timer_disp),
        .stop_disp(stop_disp),
        .mode(mode),
        .watch_en(watch_en),
        .timer_en(timer_en),
        .stop_en(stop_en),
        .watch_btn(watch_btn),
        .timer_btn(timer_btn),
        .stop_btn(stop_btn),
        .disp(disp)
    );

    clock_watch #(
        .SEC_DIV(SEC_DIV)
    ) u_clock_watch (
        .clk(clk),
        .reset_p(reset_p),
        .enable(watch_en),
        .btn(watch_btn),
        .disp(watch_disp)
    );

    // alarm stays visible in every mode
    cook_timer #(
        .SEC_DIV(SEC_DIV)
    ) u_cook_timer (
        .clk(clk),
        .reset_p(reset_p),
        .enable(timer_en),
        .btn(timer_btn),
        .disp(timer_disp),
        .alarm(alarm)
    );

    stop_watch #(
        .CSEC_DIV(CSEC_DIV)
    ) u_stop_watch (
        .clk(clk),
        .reset_p(reset_p),
        .enable(stop_en),
        .btn(stop_btn),
        .disp(stop_disp)
    );

endmodule

// ==== rtl/stop_watch.sv ====
`timescale 1ns/100ps

module stop_watch #(
    parameter int CSEC_DIV = 1_000_000
) (
    input  logic             clk,
    input  logic             reset_p,
    input  logic             enable,
    input  timer_pkg::btn_t  btn,
    output timer_pkg::disp_t disp
);
    // b0 start/stop, b1 lap, b2 clear
    logic running;
    logic lap_view;
    logic csec_tick;
    // hi = seconds, lo = centiseconds
    timer_pkg::disp_t live;
    timer_pkg::disp_t lap_val;

    // clear also restarts the centisecond phase
    tick_gen #(
        .DIV(CSEC_DIV)
    ) u_tick_gen (
        .clk(clk),
        .reset_p(reset_p),
        .run(enable && running),
        .clear(enable && btn.b2),
        .tick(csec_tick)
    );

    ////////////////////////////////////////////////////////////////////////////
    // run flag and live count
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b0;
            live <= '0;
        end else if (enable) begin
            // start wins over clear in the same cycle
            if (btn.b0) begin
                running <= ~running;
            end else if (btn.b2) begin
                running <= 1'b0;
            end
            if (csec_tick) begin
                live.lo <= timer_pkg::wrap_inc(live.lo, timer_pkg::csec_max);
                if (live.lo == timer_pkg::csec_max) begin
                    live.hi <= timer_pkg::wrap_inc(live.hi, timer_pkg::sec_max);
                end
            end
            if (btn.b2) begin
                live <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lap capture and registered display
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            lap_view <= 1'b0;
            lap_val <= '0;
            disp <= '0;
        end else if (enable) begin
            if (btn.b1) begin
                // view toggles only while counting
                if (running) begin
                    lap_view <= ~lap_view;
                end
                lap_val <= live;
            end
            if (btn.b2) begin
                lap_view <= 1'b0;
                lap_val <= '0;
            end
            disp <= lap_view ? lap_val : live;
        end
    end

endmodule

// ==== rtl/tick_gen.sv ====
`timescale 1ns/100ps

module tick_gen #(
    parameter int DIV = 100_000_000
) (
    input  logic clk,
    input  logic reset_p,
    input  logic run,
    input  logic clear,
    output logic tick
);
    // at least one bit even for DIV of 1
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // last count of the period while running
    assign tick = run && (cnt == CNT_W'(DIV - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cnt <= '0;
        end else if (clear) begin
            // restart the sub-tick phase
            cnt <= '0;
        end else if (run) begin
            cnt <= tick ? '0 : cnt + CNT_W'(1);
        end
    end

endmodule

// ==== rtl/timer_pkg.sv ====
package timer_pkg;

    // one display field, wide enough for 0..99
    localparam int unsigned time_w = 8;

    // last value before wrap, seconds and minutes share it
    localparam logic [time_w-1:0] sec_max = time_w'(59);
    localparam logic [time_w-1:0] csec_max = time_w'(99);

    // active function, stepped by the mode button
    typedef enum logic [1:0] {
        mode_watch = 2'd0,
        mode_timer = 2'd1,
        mode_stop  = 2'd2
    } mode_t;

    // two-field display, hi is the left pair of digits
    typedef struct packed {
        logic [time_w-1:0] hi;
        logic [time_w-1:0] lo;
    } disp_t;

    // general buttons, single-cycle debounced pulses
    typedef struct packed {
        logic b3;
        logic b2;
        logic b1;
        logic b0;
    } btn_t;

    // count up by one, back to zero past max
    function automatic logic [time_w-1:0] wrap_inc(input logic [time_w-1:0] v,
                                                   input logic [time_w-1:0] max);
        return (v >= max) ? '0 : v + time_w'(1);
    endfunction

endpackage

// ==== sim/tb_multi_timer.sv ====
`timescale 1ns/100ps

module tb_multi_timer;

    // short ticks for simulation
    localparam int sec_div = 10;
    localparam int csec_div = 4;
    // tests take about 1400 cycles, limit well above that
    localparam int max_cycles = 4000;

    localparam timer_pkg::btn_t btn_b0 = 4'b0001;
    localparam timer_pkg::btn_t btn_b1 = 4'b0010;
    localparam timer_pkg::btn_t btn_b2 = 4'b0100;
    localparam timer_pkg::btn_t btn_b3 = 4'b1000;

    logic clk = 1'b0;
    logic reset_p;
    logic mode_btn;
    timer_pkg::btn_t btn;
    timer_pkg::disp_t disp;
    timer_pkg::mode_t mode;
    logic alarm;

    // posedges since time zero
    int cyc = 0;
    integer seed = 32'hd233;

    multi_timer_top #(
        .SEC_DIV(sec_div),
        .CSEC_DIV(csec_div)
    ) u_multi_timer_top (
        .clk(clk),
        .reset_p(reset_p),
        .mode_btn(mode_btn),
        .btn(btn),
        .disp(disp),
        .mode(mode),
        .alarm(alarm)
    );

    // 4 ns period
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("timeout after %0d cycles, run did not finish", cyc);
            abort_run();
        end
    end

    task automatic check_val(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
        assert (act === exp) else begin
            $display("FAILED %s expected %h actual %h at cycle %0d", name, exp, act, cyc);
            abort_run();
        end
    endtask

    // split a running count into the two display fields
    function automatic timer_pkg::disp_t to_disp(input int units, input int per_hi);
        timer_pkg::disp_t d;
        d.hi = 8'(units / per_hi);
        d.lo = 8'(units % per_hi);
        return d;
    endfunction

    // idle gap of 0..3 cycles between presses
    function automatic int holdoff();
        return $random(seed) & 3;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one-cycle pulse, consumed at the second edge, returns mid-cycle
    task automatic press(input timer_pkg::btn_t b, input logic m);
        @(posedge clk);
        btn <= b;
        mode_btn <= m;
        @(posedge clk);
        btn <= '0;
        mode_btn <= 1'b0;
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    initial begin
        int w0;
        int t0;
        int s0;
        int exp_lo;
        int secs;
        int lap_cs;
        reset_p <= 1'b1;
        mode_btn <= 1'b0;
        btn <= '0;
        repeat (2) @(posedge clk);
        reset_p <= 1'b0;
        @(negedge clk);
        check_val("disp", 16'h0000, disp);
        check_val("alarm", 16'h0000, 16'(alarm));
        check_val("mode", 16'(timer_pkg::mode_watch), 16'(mode));

        // watch runs from release, one second per sec_div edges
        w0 = cyc;
        while (cyc - w0 < 65 * sec_div) begin
            @(negedge clk);
            check_val("disp", to_disp((cyc - w0) / sec_div, 60), disp);
        end
        check_val("disp", {8'd1, 8'd5}, disp);

        // set mode, seconds wrap alone
        press(btn_b0, 1'b0);
        check_val("disp", {8'd1, 8'd5}, disp);
        exp_lo = 5;
        repeat (55) begin
            press(btn_b1, 1'b0);
            exp_lo = (exp_lo == 59) ? 0 : exp_lo + 1;
            check_val("disp", to_disp(60 + exp_lo, 60), disp);
            idle(holdoff());
        end
        // watch running again, so only the idle mode can hold it
        press(btn_b0, 1'b0);
        check_val("disp", {8'd1, 8'd0}, disp);

        ////////////////////////////////////////////////////////////////////////
        // cook timer
        press('0, 1'b1);
        check_val("mode", 16'(timer_pkg::mode_timer), 16'(mode));
        check_val("disp", 16'h0000, disp);
        repeat (3) begin
            press(btn_b1, 1'b0);
            idle(holdoff());
        end
        check_val("disp", {8'd0, 8'd3}, disp);
        // stores 00:03 as preset
        press(btn_b3, 1'b0);
        check_val("disp", {8'd0, 8'd3}, disp);
        check_val("alarm", 16'h0000, 16'(alarm));
        press(btn_b0, 1'b0);
        t0 = cyc;
        while (!alarm) begin
            if (cyc - t0 > 3 * sec_div + 2) begin
                $display("alarm did not rise within %0d cycles of start", 3 * sec_div + 2);
                abort_run();
            end
            secs = (cyc - t0 >= 3 * sec_div) ? 0 : 3 - (cyc - t0) / sec_div;
            check_val("disp", to_disp(secs, 60), disp);
            @(negedge clk);
        end
        check_val("disp", 16'h0000, disp);
        // alarm off at zero recalls preset
        press(btn_b3, 1'b0);
        check_val("alarm", 16'h0000, 16'(alarm));
        check_val("disp", {8'd0, 8'd3}, disp);

        ////////////////////////////////////////////////////////////////////////
        // stopwatch, display lags live count by one edge
        press('0, 1'b1);
        check_val("mode", 16'(timer_pkg::mode_stop), 16'(mode));
        check_val("disp", 16'h0000, disp);
        press(btn_b0, 1'b0);
        s0 = cyc;
        while (cyc - s0 < 420) begin
            @(negedge clk);
            check_val("disp", to_disp((cyc - s0 - 1) / csec_div, 100), disp);
        end
        // first lap freezes the view
        press(btn_b1, 1'b0);
        lap_cs = (cyc - s0 - 1) / csec_div;
        check_val("disp", to_disp(lap_cs, 100), disp);
        repeat (20) begin
            @(negedge clk);
            check_val("disp", to_disp(lap_cs, 100), disp);
        end
        // second lap shows the live count again
        press(btn_b1, 1'b0);
        check_val("disp", to_disp(lap_cs, 100), disp);
        repeat (8) begin
            @(negedge clk);
            check_val("disp", to_disp((cyc - s0 - 1) / csec_div, 100), disp);
        end
        press(btn_b2, 1'b0);
        check_val("disp", to_disp((cyc - s0 - 1) / csec_div, 100), disp);
        repeat (12) begin
            @(negedge clk);
            check_val("disp", 16'h0000, disp);
        end

        // back to watch, untouched by the visit
        press('0, 1'b1);
        check_val("mode", 16'(timer_pkg::mode_watch), 16'(mode));
        check_val("disp", {8'd1, 8'd0}, disp);
        check_val("alarm", 16'h0000, 16'(alarm));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/timer_pkg.sv
rtl/tick_gen.sv
rtl/clock_watch.sv
rtl/cook_timer.sv
rtl/stop_watch.sv
rtl/mode_ctrl.sv
rtl/multi_timer_top.sv
sim/tb_multi_timer.sv
